//--- render.f
hw/render_pkg.sv
hw/cmd_regs.sv
hw/solid_plotter.sv
hw/sprite_blitter.sv
hw/frame_store.sv
hw/render_top.sv
tb/render_tb.sv

//--- Makefile
RTL = hw/render_pkg.sv hw/cmd_regs.sv hw/solid_plotter.sv hw/sprite_blitter.sv \
      hw/frame_store.sv hw/render_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only $(RTL) --top-module render_top
	verilator --lint-only --timing -f render.f --top-module render_tb

obj_dir/Vrender_tb: render.f $(RTL) tb/render_tb.sv
	verilator --binary --timing -j 0 -f render.f --top-module render_tb

sim: obj_dir/Vrender_tb
	./obj_dir/Vrender_tb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hw/birds.hex
// One line per sprite column, rows 0 to 11, each texel T_RR_GG_BB with T set when opaque
2a 2a 2a 2a 2a 70 70 2a 2a 2a 2a 2a
2a 2a 2a 2a 70 70 70 70 2a 2a 2a 2a
2a 2a 2a 70 70 70 70 70 70 2a 2a 2a
2a 2a 70 70 70 70 70 70 70 70 2a 2a
2a 70 70 70 70 70 70 70 70 70 70 2a
70 70 70 70 70 70 70 70 70 70 70 70
70 70 70 70 70 70 70 70 70 70 70 70
70 70 70 70 70 70 70 70 70 70 70 70
70 70 70 70 70 70 70 70 70 70 70 70
70 70 70 70 70 70 70 70 70 70 70 70
70 70 70 70 70 70 70 70 70 70 70 70
70 70 70 70 70 70 70 70 70 70 70 70
70 70 70 7f 70 70 70 70 70 70 70 70
2a 70 70 70 70 70 70 70 70 70 70 2a
2a 2a 70 70 70 70 70 70 70 70 2a 2a
2a 2a 2a 70 70 70 74 70 70 2a 2a 2a
2a 2a 2a 2a 70 70 74 70 2a 2a 2a 2a
2a 2a 2a 2a 2a 70 74 2a 2a 2a 2a 2a
15 15 15 15 15 7c 7c 15 15 15 15 15
15 15 15 15 7c 7c 7c 7c 15 15 15 15
15 15 15 7c 7c 7c 7c 7c 7c 15 15 15
15 15 7c 7c 7c 7c 7c 7c 7c 7c 15 15
15 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 15
7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c
7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c
7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c
7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c
7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c
7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c
7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c
7c 7c 7c 7f 7c 7c 7c 7c 7c 7c 7c 7c
15 7c 7c 7c 7c 7c 7c 7c 7c 7c 7c 15
15 15 7c 7c 7c 7c 7c 7c 7c 7c 15 15
15 15 15 7c 7c 7c 74 7c 7c 15 15 15
15 15 15 15 7c 7c 74 7c 15 15 15 15
15 15 15 15 15 7c 74 15 15 15 15 15
00 00 00 00 00 43 43 00 00 00 00 00
00 00 00 00 43 43 43 43 00 00 00 00
00 00 00 43 43 43 43 43 43 00 00 00
00 00 43 43 43 43 43 43 43 43 00 00
00 43 43 43 43 43 43 43 43 43 43 00
43 43 43 43 43 43 43 43 43 43 43 43
43 43 43 43 43 43 43 43 43 43 43 43
43 43 43 43 43 43 43 43 43 43 43 43
43 43 43 43 43 43 43 43 43 43 43 43
43 43 43 43 43 43 43 43 43 43 43 43
43 43 43 43 43 43 43 43 43 43 43 43
43 43 43 43 43 43 43 43 43 43 43 43
43 43 43 7f 43 43 43 43 43 43 43 43
00 43 43 43 43 43 43 43 43 43 43 00
00 00 43 43 43 43 43 43 43 43 00 00
00 00 00 43 43 43 74 43 43 00 00 00
00 00 00 00 43 43 74 43 00 00 00 00
00 00 00 00 00 43 74 00 00 00 00 00
3f 3f 3f 3f 3f 4c 4c 3f 3f 3f 3f 3f
3f 3f 3f 3f 4c 4c 4c 4c 3f 3f 3f 3f
3f 3f 3f 4c 4c 4c 4c 4c 4c 3f 3f 3f
3f 3f 4c 4c 4c 4c 4c 4c 4c 4c 3f 3f
3f 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 3f
4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c
4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c
4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c
4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c
4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c
4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c
4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c
4c 4c 4c 7f 4c 4c 4c 4c 4c 4c 4c 4c
3f 4c 4c 4c 4c 4c 4c 4c 4c 4c 4c 3f
3f 3f 4c 4c 4c 4c 4c 4c 4c 4c 3f 3f
3f 3f 3f 4c 4c 4c 74 4c 4c 3f 3f 3f
3f 3f 3f 3f 4c 4c 74 4c 3f 3f 3f 3f
3f 3f 3f 3f 3f 4c 74 3f 3f 3f 3f 3f

//--- tb/render_tb.sv
module render_tb
    import render_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDLE_TIMEOUT = 80000;

    logic        clk;
    logic        rst_n;
    logic [3:0]  address;
    logic        write;
    logic [31:0] writedata;
    logic        waitrequest;
    fb_addr_t    pix_addr;
    pixel_t      pix_q;

    // Reference model state
    pixel_t      frame [FRAME_WORDS];
    logic [6:0]  birds [BIRD_COUNT * BIRD_WORDS];
    logic [31:0] seed;
    logic        m_neg;
    int          m_x;
    int          m_y;
    logic [6:0]  m_tex;

    render_top render_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .address     (address),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .pix_addr    (pix_addr),
        .pix_q       (pix_q)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (expected !== actual) begin
            $display("MISMATCH at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Applies one draw command to the model frame
    function automatic void plot_model();
        int         code;
        int         x;
        int         y;
        logic [6:0] t;
        code = int'(m_tex[5:0]);
        if (m_tex[6]) begin
            for (int i = 0; i < FRAME_WORDS; i++) frame[17'(i)] = m_tex[5:0];
        end else if (code == 31) begin
            for (int i = 0; i < SCREEN_H; i++) frame[17'(SPLIT_X * SCREEN_H + i)] = '0;
        end else if (code >= 1 && code <= BIRD_COUNT) begin
            for (int c = 0; c < BIRD_W; c++) begin
                for (int r = 0; r < BIRD_H; r++) begin
                    x = m_x - BIRD_W / 2 + c;
                    y = m_y - BIRD_H / 2 + r;
                    t = birds[10'((code - 1) * BIRD_WORDS + c * BIRD_H + r)];
                    if (t[6] && x >= 0 && x < SCREEN_W && y >= 0 && y < SCREEN_H) begin
                        frame[17'(x * SCREEN_H + y)] = t[5:0];
                    end
                end
            end
        end
    endfunction

    // One bus cycle that the DUT may drop
    task automatic bus_write(input logic [3:0] a, input logic [31:0] d);
        address   = a;
        writedata = d;
        write     = 1'b1;
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic reg_write(input logic [3:0] a, input logic [31:0] d);
        check_equal(32'd0, 32'(waitrequest), "waitrequest before register write");
        bus_write(a, d);
        case (a)
            REG_MID_X: m_x = m_neg ? -int'(d[8:0]) : int'(d[8:0]);
            REG_MID_Y: m_y = m_neg ? -int'(d[7:0]) : int'(d[7:0]);
            REG_NEG:   m_neg = d[0];
            REG_TEX:   m_tex = d[6:0];
            REG_START: plot_model();
            default: ;
        endcase
    endtask

    task automatic wait_idle(output int cycles);
        cycles = 0;
        while (waitrequest && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (waitrequest) begin
            $display("ERROR: waitrequest stayed high for %0d cycles after a start", cycles);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic run_plot(output int cycles);
        reg_write(REG_START, 32'd0);
        check_equal(32'd1, 32'(waitrequest), "waitrequest after start");
        wait_idle(cycles);
    endtask

    // Each pixel is checked one cycle after its address
    task automatic check_frame(input string what);
        pix_addr = '0;
        for (int a = 1; a <= FRAME_WORDS; a++) begin
            @(negedge clk);
            check_equal(32'(frame[17'(a - 1)]), 32'(pix_q),
                        $sformatf("pixel %0d after %s", a - 1, what));
            if (a < FRAME_WORDS) pix_addr = fb_addr_t'(a);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] xr;
        logic [31:0] yr;
        logic [5:0]  color;
        logic        negf;
        int          code;
        int          cycles;
        clk       = 1'b0;
        rst_n     = 1'b0;
        address   = '0;
        write     = 1'b0;
        writedata = '0;
        pix_addr  = '0;
        seed      = 32'h4dc;
        m_neg     = 1'b0;
        m_x       = 0;
        m_y       = 0;
        m_tex     = '0;
        $readmemh("hw/birds.hex", birds);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_equal(32'd0, 32'(waitrequest), "waitrequest after reset");

        // Nonzero colour so the black split line shows
        r     = next_random();
        color = r[5:0] | 6'h20;
        reg_write(REG_TEX, {25'd0, 1'b1, color});
        run_plot(cycles);
        check_frame("fill");

        reg_write(REG_TEX, 32'd31);
        run_plot(cycles);
        check_frame("split line");

        for (int i = 0; i < 20; i++) begin
            r    = next_random();
            negf = (r[1:0] == 2'b00);
            code = int'(r[3:2]) + 1;
            r    = next_random();
            // Negated centres stay close to the origin so part of the bird shows
            if (negf) begin
                xr = r % 32'd12;
                yr = (r >> 8) % 32'd10;
            end else begin
                xr = r % 32'd340;
                yr = (r >> 12) % 32'd256;
            end
            reg_write(REG_NEG, {31'd0, negf});
            reg_write(REG_MID_X, xr);
            reg_write(REG_MID_Y, yr);
            reg_write(REG_TEX, 32'(code));
            run_plot(cycles);
            check_frame($sformatf("bird plot %0d", i));
        end

        // Writes during a fill must be dropped
        reg_write(REG_NEG, 32'd0);
        r     = next_random();
        color = r[5:0];
        reg_write(REG_TEX, {25'd0, 1'b1, color});
        reg_write(REG_START, 32'd0);
        bus_write(REG_TEX, {25'd0, 1'b1, color ^ 6'h15});
        bus_write(REG_NEG, 32'd1);
        bus_write(REG_START, 32'd0);
        wait_idle(cycles);
        // A fill releases waitrequest FRAME_WORDS + 2 cycles after its start write
        check_equal(32'(FRAME_WORDS + 2 - 3), 32'(cycles), "fill time with dropped writes");
        check_frame("fill with ignored writes");
        run_plot(cycles);
        check_frame("repeated fill");
        reg_write(REG_MID_X, 32'd100);
        reg_write(REG_MID_Y, 32'd100);
        reg_write(REG_TEX, 32'd2);
        run_plot(cycles);
        check_frame("bird after ignored writes");

        // Codes that select nothing release waitrequest at once
        for (int i = 0; i < 2; i++) begin
            reg_write(REG_TEX, (i == 0) ? 32'd25 : 32'd0);
            run_plot(cycles);
            check_equal(32'd1, 32'(cycles), "release delay for unused code");
            check_frame("unused code");
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- hw/render_top.sv
module render_top
    import render_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  address,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    input  fb_addr_t    pix_addr,
    output pixel_t      pix_q
);

    draw_cmd_t cmd;
    logic      solid_start;
    logic      sprite_start;
    logic      solid_done;
    logic      sprite_done;
    fb_write_t solid_wr;
    fb_write_t sprite_wr;

    cmd_regs cmd_regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .write        (write),
        .writedata    (writedata),
        .waitrequest  (waitrequest),
        .cmd          (cmd),
        .solid_start  (solid_start),
        .sprite_start (sprite_start),
        .solid_done   (solid_done),
        .sprite_done  (sprite_done)
    );

    solid_plotter solid_plotter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (solid_start),
        .cmd   (cmd),
        .done  (solid_done),
        .wr    (solid_wr)
    );

    sprite_blitter sprite_blitter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (sprite_start),
        .cmd   (cmd),
        .done  (sprite_done),
        .wr    (sprite_wr)
    );

    frame_store frame_store_i (
        .clk       (clk),
        .solid_wr  (solid_wr),
        .sprite_wr (sprite_wr),
        .pix_addr  (pix_addr),
        .pix_q     (pix_q)
    );

endmodule

//--- hw/frame_store.sv
module frame_store
    import render_pkg::*;
(
    input  logic      clk,
    input  fb_write_t solid_wr,
    input  fb_write_t sprite_wr,
    input  fb_addr_t  pix_addr,
    output pixel_t    pix_q
);

    pixel_t    mem [FRAME_WORDS];
    fb_write_t wr;

    // Only one plotter drives a non-zero stream at a time
    assign wr = solid_wr | sprite_wr;

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        pix_q <= mem[pix_addr];
    end

endmodule

//--- hw/sprite_blitter.sv
module sprite_blitter
    import render_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  draw_cmd_t cmd,
    output logic      done,
    output fb_write_t wr
);

    // Texels are T_RR_GG_BB, stored column by column per bird
    logic [6:0] rom [BIRD_COUNT * BIRD_WORDS];

    initial begin
        $readmemh("hw/birds.hex", rom);
    end

    logic       busy;
    logic [4:0] col;
    logic [3:0] row;
    logic [9:0] tex_addr;
    coord_t     x0;
    coord_t     y0;
    coord_t     cur_x;
    coord_t     cur_y;
    logic       row_last;
    logic       col_last;
    logic       in_range;

    logic [6:0] rom_q;
    fb_addr_t   s1_addr;
    logic       s1_hit;
    logic       s1_last;

    assign row_last = (row == 4'(BIRD_H - 1));
    assign col_last = (col == 5'(BIRD_W - 1));
    assign cur_x    = x0 + coord_t'(col);
    assign cur_y    = y0 + coord_t'(row);

    // Clip to the visible screen
    assign in_range = !cur_x[9] && (cur_x < coord_t'(SCREEN_W)) &&
                      !cur_y[9] && (cur_y < coord_t'(SCREEN_H));

    // Scan rows inside each column
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            col  <= '0;
            row  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            col  <= '0;
            row  <= '0;
        end else if (busy) begin
            if (row_last) begin
                row <= '0;
                col <= col + 5'd1;
                if (col_last) begin
                    busy <= 1'b0;
                end
            end else begin
                row <= row + 4'd1;
            end
        end
    end

    // Sprite origin and texture base
    always_ff @(posedge clk) begin
        if (start) begin
            tex_addr <= 10'(cmd.tex.sprite_view.code - CODE_BIRD_FIRST) * 10'(BIRD_WORDS);
            x0       <= cmd.mid_x - coord_t'(BIRD_W / 2);
            y0       <= cmd.mid_y - coord_t'(BIRD_H / 2);
        end else if (busy) begin
            tex_addr <= tex_addr + 10'd1;
        end
    end

    // ROM stage, frame address travels alongside the texel
    always_ff @(posedge clk) begin
        rom_q   <= rom[tex_addr];
        s1_addr <= fb_addr_t'(cur_x[8:0]) * fb_addr_t'(SCREEN_H) + fb_addr_t'(cur_y[7:0]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_hit  <= 1'b0;
            s1_last <= 1'b0;
            done    <= 1'b0;
        end else begin
            s1_hit  <= busy && in_range;
            s1_last <= busy && row_last && col_last;
            done    <= s1_last;
        end
    end

    // Transparent texels write nothing
    always_comb begin
        wr = '0;
        if (s1_hit && rom_q[6]) begin
            wr.en   = 1'b1;
            wr.addr = s1_addr;
            wr.data = rom_q[5:0];
        end
    end

endmodule

//--- hw/solid_plotter.sv
module solid_plotter
    import render_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  draw_cmd_t cmd,
    output logic      done,
    output fb_write_t wr
);

    logic     busy;
    logic     split;
    fb_addr_t cnt;
    fb_addr_t last;
    pixel_t   color;

    // Split line walks one column, a fill walks the whole frame
    assign last = split ? fb_addr_t'(SCREEN_H - 1) : fb_addr_t'(FRAME_WORDS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            split <= 1'b0;
            cnt   <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                split <= !cmd.tex.fill_view.fill;
                cnt   <= '0;
            end else if (busy) begin
                cnt <= cnt + 17'd1;
                if (cnt == last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Split line is drawn black
    always_ff @(posedge clk) begin
        if (start) begin
            color <= cmd.tex.fill_view.fill ? cmd.tex.fill_view.color : '0;
        end
    end

    // Idle output stays zero so the frame store can OR the streams
    always_comb begin
        wr = '0;
        if (busy) begin
            wr.en   = 1'b1;
            wr.addr = split ? fb_addr_t'(SPLIT_X * SCREEN_H) + cnt : cnt;
            wr.data = color;
        end
    end

endmodule

//--- hw/cmd_regs.sv
module cmd_regs
    import render_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  address,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output draw_cmd_t   cmd,
    output logic        solid_start,
    output logic        sprite_start,
    input  logic        solid_done,
    input  logic        sprite_done
);

    logic   neg;
    logic   none_done;
    logic   accept;
    logic   pick_solid;
    logic   pick_sprite;
    coord_t x_in;
    coord_t y_in;

    // Writes during a plot are dropped
    assign accept = write && !waitrequest;

    assign x_in = neg ? -coord_t'({1'b0, writedata[8:0]}) : coord_t'({1'b0, writedata[8:0]});
    assign y_in = neg ? -coord_t'({2'b0, writedata[7:0]}) : coord_t'({2'b0, writedata[7:0]});

    assign pick_solid  = cmd.tex.fill_view.fill || (cmd.tex.sprite_view.code == CODE_SPLIT);
    // Codes below the first bird wrap high and fall out of range
    assign pick_sprite = !cmd.tex.sprite_view.fill &&
                         ((cmd.tex.sprite_view.code - CODE_BIRD_FIRST) < 6'(BIRD_COUNT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waitrequest  <= 1'b0;
            solid_start  <= 1'b0;
            sprite_start <= 1'b0;
            none_done    <= 1'b0;
            neg          <= 1'b0;
            cmd          <= '0;
        end else begin
            solid_start  <= 1'b0;
            sprite_start <= 1'b0;
            none_done    <= 1'b0;
            if (accept) begin
                case (address)
                    REG_MID_X: cmd.mid_x <= x_in;
                    REG_MID_Y: cmd.mid_y <= y_in;
                    REG_NEG:   neg <= writedata[0];
                    REG_TEX:   cmd.tex <= tex_code_u'(writedata[6:0]);
                    REG_START: begin
                        waitrequest  <= 1'b1;
                        solid_start  <= pick_solid;
                        sprite_start <= pick_sprite;
                        none_done    <= !pick_solid && !pick_sprite;
                    end
                    default: ;
                endcase
            end else if (solid_done || sprite_done || none_done) begin
                waitrequest <= 1'b0;
            end
        end
    end

endmodule

//--- hw/render_pkg.sv
package render_pkg;

    // Screen geometry, pixels are stored column by column
    localparam int SCREEN_W    = 320;
    localparam int SCREEN_H    = 240;
    localparam int FRAME_WORDS = SCREEN_W * SCREEN_H;
    localparam int SPLIT_X     = 159;

    // Bird sprites
    localparam int BIRD_W     = 18;
    localparam int BIRD_H     = 12;
    localparam int BIRD_WORDS = BIRD_W * BIRD_H;
    localparam int BIRD_COUNT = 4;

    localparam logic [5:0] CODE_BIRD_FIRST = 6'd1;
    localparam logic [5:0] CODE_SPLIT      = 6'd31;

    // CPU register map
    localparam logic [3:0] REG_MID_X = 4'd1;
    localparam logic [3:0] REG_MID_Y = 4'd2;
    localparam logic [3:0] REG_NEG   = 4'd3;
    localparam logic [3:0] REG_TEX   = 4'd4;
    localparam logic [3:0] REG_START = 4'd6;

    typedef logic [5:0]        pixel_t;
    typedef logic [16:0]       fb_addr_t;
    typedef logic signed [9:0] coord_t;

    typedef struct packed {
        logic   fill;
        pixel_t color;
    } tex_fill_t;

    typedef struct packed {
        logic       fill;
        logic [5:0] code;
    } tex_sprite_t;

    // Top bit picks the view
    typedef union packed {
        tex_fill_t   fill_view;
        tex_sprite_t sprite_view;
    } tex_code_u;

    typedef struct packed {
        coord_t    mid_x;
        coord_t    mid_y;
        tex_code_u tex;
    } draw_cmd_t;

    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        pixel_t   data;
    } fb_write_t;

endpackage
